/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_uart_tx
FILELIST  = uart_tx.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS   = uart_config.svh

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_uart_tx.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_tx;

	localparam int clk_period = 20;
	localparam int fifo_depth = 1 << `UART_FIFO_AW;
	localparam int burst_len  = 24;
	// One byte at 4, the burst at 4, three at 7 and two at 2 clocks per bit
	localparam int frame_clocks = 10 * (1 * 4 + burst_len * 4 + 3 * 7 + 2 * 2);
	localparam int cycle_limit  = frame_clocks * 3 / 2 + 2000;

	logic              i_CLK;
	logic              i_RESET;
	uart_pkg::wb_req_t wb_req;
	uart_pkg::wb_rsp_t wb_rsp;
	logic              tx;

	logic [31:0]       lfsr;
	logic [7:0]        expected [$];
	int unsigned       cycle;
	int unsigned       bit_clocks;
	int unsigned       back_to_back;
	logic              in_frame;
	logic              reset_done;

	uart_tx_top i_uart_tx_top (
		.i_CLK   (i_CLK),
		.i_RESET (i_RESET),
		.i_wb    (wb_req),
		.o_wb    (wb_rsp),
		.o_tx    (tx)
	);

	initial
	begin
		i_CLK = 1'b0;
		forever
			#(clk_period / 2) i_CLK = ~i_CLK;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			stop_on_error($sformatf("mismatch at %0t: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	always @(posedge i_CLK)
	begin
		cycle = cycle + 1;
		if (cycle > cycle_limit)
			stop_on_error($sformatf("timeout after %0d clock cycles", cycle_limit));
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// Status word with busy on top, then full and empty above the level
	function automatic logic [31:0] status_word(input logic busy, input logic full,
		input logic empty, input int level);
		logic [31:0] w;
		w = '0;
		w[`UART_FIFO_AW:0]   = level[`UART_FIFO_AW:0];
		w[`UART_FIFO_AW + 1] = empty;
		w[`UART_FIFO_AW + 2] = full;
		w[`UART_FIFO_AW + 3] = busy;
		return w;
	endfunction

	task automatic wb_access(input logic we, input uart_pkg::reg_addr_e adr,
		input logic [31:0] wdata, output logic [31:0] rdata, output int waits);
		waits      = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdata;
		do
		begin
			@(posedge i_CLK);
			#2;
			waits++;
		end
		while (!wb_rsp.ack);
		rdata  = wb_rsp.dat;
		wb_req = '0;
		// One idle cycle before the next request
		@(posedge i_CLK);
		#2;
	endtask

	task automatic wb_write(input uart_pkg::reg_addr_e adr, input logic [31:0] data);
		logic [31:0] rdata;
		int          waits;
		wb_access(1'b1, adr, data, rdata, waits);
	endtask

	task automatic wb_read(input uart_pkg::reg_addr_e adr, output logic [31:0] data);
		int waits;
		wb_access(1'b0, adr, '0, data, waits);
	endtask

	task automatic send_byte(input logic [7:0] b, output int waits);
		logic [31:0] rdata;
		expected.push_back(b);
		wb_access(1'b1, uart_pkg::REG_DATA, {24'b0, b}, rdata, waits);
	endtask

	task automatic set_divisor(input int unsigned d);
		wb_write(uart_pkg::REG_DIVISOR, d);
		// Divisors below 2 run at 2
		bit_clocks = (d < 2) ? 2 : d;
	endtask

	task automatic wait_idle();
		logic [31:0] rdata;
		while (expected.size() != 0 || in_frame)
		begin
			@(posedge i_CLK);
			#2;
		end
		// Busy drops on the tick that ends the stop bit
		do
			wb_read(uart_pkg::REG_STATUS, rdata);
		while (rdata[`UART_FIFO_AW + 3]);
		check_value("status when idle", rdata, status_word(1'b0, 1'b0, 1'b1, 0));
	endtask

	// Serial monitor samples once per clock and takes data mid bit
	initial
	begin : serial_monitor
		int unsigned d;
		int unsigned start_cycle;
		int unsigned last_start;
		logic        have_last;
		logic        first;
		logic        mid;
		logic [7:0]  data;

		have_last  = 1'b0;
		last_start = 0;
		wait (reset_done === 1'b1);
		forever
		begin
			@(negedge tx);
			d           = bit_clocks;
			start_cycle = cycle;
			in_frame    = 1'b1;
			if (have_last && start_cycle - last_start == 10 * d)
				back_to_back++;
			last_start = start_cycle;
			have_last  = 1'b1;
			#1;
			for (int k = 0; k < 10; k++)
			begin
				for (int c = 0; c < d; c++)
				begin
					if (k != 0 || c != 0)
					begin
						@(posedge i_CLK);
						#1;
					end
					if (c == 0)
						first = tx;
					check_value($sformatf("o_tx inside bit %0d", k), {31'b0, tx}, {31'b0, first});
					if (c == d / 2)
						mid = tx;
				end
				if (k == 0)
					check_value("start bit", {31'b0, mid}, 32'd0);
				else if (k == 9)
					check_value("stop bit", {31'b0, mid}, 32'd1);
				else
					data[k - 1] = mid;
			end
			if (expected.size() == 0)
				stop_on_error("a frame arrived with no byte written");
			check_value("serial byte", {24'b0, data}, {24'b0, expected.pop_front()});
			in_frame = 1'b0;
		end
	end

	initial
	begin : stimulus
		logic [31:0] rdata;
		int          waits;
		int unsigned b2b_start;

		i_RESET      = 1'b1;
		wb_req       = '0;
		lfsr         = 32'h58bc_5de7;
		cycle        = 0;
		bit_clocks   = `UART_DIV_RESET;
		back_to_back = 0;
		in_frame     = 1'b0;
		reset_done   = 1'b0;
		repeat (3) @(posedge i_CLK);
		#2;
		i_RESET    = 1'b0;
		reset_done = 1'b1;

		// Line stays idle over two bit periods at the reset divisor
		repeat (2 * `UART_DIV_RESET)
		begin
			check_value("o_tx after reset", {31'b0, tx}, 32'd1);
			@(posedge i_CLK);
			#2;
		end
		wb_read(uart_pkg::REG_STATUS, rdata);
		check_value("status after reset", rdata, status_word(1'b0, 1'b0, 1'b1, 0));
		wb_read(uart_pkg::REG_DIVISOR, rdata);
		check_value("divisor after reset", rdata, `UART_DIV_RESET);

		// Single frame at four clocks per bit
		set_divisor(4);
		send_byte(random_byte(), waits);
		while (!in_frame)
		begin
			@(posedge i_CLK);
			#2;
		end
		wb_read(uart_pkg::REG_STATUS, rdata);
		check_value("status during a frame", rdata, status_word(1'b1, 1'b0, 1'b1, 0));
		wait_idle();

		// Burst where one byte is popped and the rest fill the FIFO
		b2b_start = back_to_back;
		for (int i = 0; i <= fifo_depth; i++)
			send_byte(random_byte(), waits);
		wb_read(uart_pkg::REG_STATUS, rdata);
		check_value("status with a full FIFO", rdata,
			status_word(1'b1, 1'b1, 1'b0, fifo_depth));
		for (int i = fifo_depth + 1; i < burst_len; i++)
		begin
			send_byte(random_byte(), waits);
			if (i == fifo_depth + 1)
			begin
				assert (waits > 1)
				else
					stop_on_error("a write to the full FIFO was acknowledged without waiting");
			end
		end
		wait_idle();
		check_value("back-to-back frames in the burst", back_to_back - b2b_start,
			burst_len - 1);

		// Rate change to seven clocks per bit
		set_divisor(7);
		wb_read(uart_pkg::REG_DIVISOR, rdata);
		check_value("divisor read back", rdata, 7);
		for (int i = 0; i < 3; i++)
			send_byte(random_byte(), waits);
		wait_idle();

		// Register map edges
		wb_write(uart_pkg::REG_STATUS, 32'hffff_ffff);
		wb_read(uart_pkg::REG_STATUS, rdata);
		check_value("status after a status write", rdata, status_word(1'b0, 1'b0, 1'b1, 0));
		wb_read(uart_pkg::REG_DIVISOR, rdata);
		check_value("divisor after a status write", rdata, 7);
		wb_read(uart_pkg::REG_DATA, rdata);
		check_value("data register read", rdata, 0);
		set_divisor(1);
		for (int i = 0; i < 2; i++)
			send_byte(random_byte(), waits);
		wait_idle();

		if (expected.size() == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
			stop_on_error("bytes were written but never seen on the serial line");
	end

endmodule

/* uart_baud_gen.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_baud_gen (
	input  logic                    i_CLK,
	input  logic                    i_RESET,
	input  logic [`UART_DIV_W-1:0]  i_divisor,
	output logic                    o_tick
);

	logic [`UART_DIV_W-1:0] reload;
	logic [`UART_DIV_W-1:0] count;
	logic [`UART_DIV_W-1:0] divisor_q;

	// Divisors below 2 count as 2
	assign reload = (i_divisor > 1) ? i_divisor - 1'b1 : {{(`UART_DIV_W-1){1'b0}}, 1'b1};

	always_ff @(posedge i_CLK)
	begin
		divisor_q <= i_divisor;
		if (i_RESET)
			count <= reload;
		else if (i_divisor != divisor_q || count == '0)
			count <= reload;
		else
			count <= count - 1'b1;
	end

	// One clock in every D
	assign o_tick = (count == '0);

endmodule

/* uart_config.svh */
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Character width on the serial line
`define UART_DATA_W     8

// Wishbone data and word address widths
`define UART_WB_DAT_W   32
`define UART_WB_ADR_W   2

// FIFO depth is 2**UART_FIFO_AW bytes
`define UART_FIFO_AW    4

// Clocks per bit, width and value after reset
`define UART_DIV_W      16
`define UART_DIV_RESET  16

`endif

/* uart_pkg.sv */
`include "uart_config.svh"

package uart_pkg;

	// Word addresses on the Wishbone port
	typedef enum logic [`UART_WB_ADR_W-1:0] {
		REG_DATA    = 0,
		REG_STATUS  = 1,
		REG_DIVISOR = 2
	} reg_addr_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [`UART_WB_ADR_W-1:0] adr;
		logic [`UART_WB_DAT_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                      ack;
		logic [`UART_WB_DAT_W-1:0] dat;
	} wb_rsp_t;

	// Status word, busy in the top bit and level in the low bits
	typedef struct packed {
		logic                    busy;
		logic                    full;
		logic                    empty;
		logic [`UART_FIFO_AW:0]  level;
	} uart_status_t;

endpackage

/* uart_transmitter.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_transmitter (
	input  logic                     i_CLK,
	input  logic                     i_RESET,
	input  logic                     i_tick,
	input  logic                     i_empty,
	input  logic [`UART_DATA_W-1:0]  i_data,
	output logic                     o_pop,
	output logic                     o_busy,
	output logic                     o_tx
);

	localparam int cnt_w = $clog2(`UART_DATA_W);
	localparam logic [cnt_w-1:0] last_bit = cnt_w'(`UART_DATA_W - 1);

	uart_pkg::tx_state_e      state;
	logic [`UART_DATA_W-1:0]  shift_reg;
	logic [cnt_w-1:0]         bit_cnt;
	logic                     load;

	// Fetch at the end of an idle bit or straight after a stop bit
	assign load = i_tick && !i_empty &&
		(state == uart_pkg::TX_IDLE || state == uart_pkg::TX_STOP);

	assign o_pop  = load;
	assign o_busy = (state != uart_pkg::TX_IDLE);

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			state   <= uart_pkg::TX_IDLE;
			bit_cnt <= '0;
			o_tx    <= 1'b1;
		end
		else if (i_tick)
		begin
			case (state)
				uart_pkg::TX_IDLE, uart_pkg::TX_STOP:
				begin
					if (!i_empty)
					begin
						state <= uart_pkg::TX_START;
						o_tx  <= 1'b0;
					end
					else
					begin
						state <= uart_pkg::TX_IDLE;
						o_tx  <= 1'b1;
					end
				end
				uart_pkg::TX_START:
				begin
					state   <= uart_pkg::TX_DATA;
					bit_cnt <= '0;
					o_tx    <= shift_reg[0];
				end
				uart_pkg::TX_DATA:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == last_bit)
					begin
						state <= uart_pkg::TX_STOP;
						o_tx  <= 1'b1;
					end
					else
						o_tx <= shift_reg[0];
				end
				default:
				begin
					state <= uart_pkg::TX_IDLE;
					o_tx  <= 1'b1;
				end
			endcase
		end
	end

	// LSB first, shifted out once per data bit
	always_ff @(posedge i_CLK)
	begin
		if (load)
			shift_reg <= i_data;
		else if (i_tick && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA))
			shift_reg <= shift_reg >> 1;
	end

	a_start_low: assert property (@(posedge i_CLK) disable iff (i_RESET)
		(state == uart_pkg::TX_START) |-> !o_tx);

	a_line_high: assert property (@(posedge i_CLK) disable iff (i_RESET)
		(state == uart_pkg::TX_IDLE || state == uart_pkg::TX_STOP) |-> o_tx);

	// Bit boundaries come only from the baud tick
	a_tick_only: assert property (@(posedge i_CLK) disable iff (i_RESET)
		!i_tick |=> $stable(state));

endmodule

/* uart_tx.f */
+incdir+.
uart_pkg.sv
uart_wb_regs.sv
uart_tx_fifo.sv
uart_baud_gen.sv
uart_transmitter.sv
uart_tx_top.sv
tb_uart_tx.sv

/* uart_tx_fifo.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_fifo (
	input  logic                      i_CLK,
	input  logic                      i_RESET,
	input  logic                      i_push,
	input  logic [`UART_DATA_W-1:0]   i_push_data,
	input  logic                      i_pop,
	output logic [`UART_DATA_W-1:0]   o_head,
	output logic                      o_full,
	output logic                      o_empty,
	output logic [`UART_FIFO_AW:0]    o_level
);

	localparam int depth = 1 << `UART_FIFO_AW;

	logic [`UART_DATA_W-1:0] mem [depth];
	// Pointers carry one extra wrap bit
	logic [`UART_FIFO_AW:0]  wr_ptr;
	logic [`UART_FIFO_AW:0]  rd_ptr;
	logic                    same_slot;

	always_ff @(posedge i_CLK)
	begin
		if (i_push)
			mem[wr_ptr[`UART_FIFO_AW-1:0]] <= i_push_data;
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign same_slot = (wr_ptr[`UART_FIFO_AW-1:0] == rd_ptr[`UART_FIFO_AW-1:0]);

	// Same slot with equal wrap bits is empty, different wrap bits is full
	assign o_empty = same_slot && (wr_ptr[`UART_FIFO_AW] == rd_ptr[`UART_FIFO_AW]);
	assign o_full  = same_slot && (wr_ptr[`UART_FIFO_AW] != rd_ptr[`UART_FIFO_AW]);
	assign o_level = wr_ptr - rd_ptr;

	// Head is read straight from the array
	assign o_head = mem[rd_ptr[`UART_FIFO_AW-1:0]];

	a_no_pop_empty: assert property (@(posedge i_CLK) disable iff (i_RESET)
		!(i_pop && o_empty));

	a_no_push_full: assert property (@(posedge i_CLK) disable iff (i_RESET)
		!(i_push && o_full));

endmodule

/* uart_tx_top.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_top (
	input  logic               i_CLK,
	input  logic               i_RESET,
	input  uart_pkg::wb_req_t  i_wb,
	output uart_pkg::wb_rsp_t  o_wb,
	output logic               o_tx
);

	logic                     push;
	logic [`UART_DATA_W-1:0]  push_data;
	logic [`UART_DIV_W-1:0]   divisor;
	logic                     fifo_full;
	logic                     fifo_empty;
	logic [`UART_FIFO_AW:0]   fifo_level;
	logic [`UART_DATA_W-1:0]  head;
	logic                     pop;
	logic                     tx_busy;
	logic                     tick;

	uart_wb_regs u_regs (
		.i_CLK        (i_CLK),
		.i_RESET      (i_RESET),
		.i_wb         (i_wb),
		.i_fifo_full  (fifo_full),
		.i_fifo_empty (fifo_empty),
		.i_fifo_level (fifo_level),
		.i_tx_busy    (tx_busy),
		.o_wb         (o_wb),
		.o_push       (push),
		.o_push_data  (push_data),
		.o_divisor    (divisor)
	);

	uart_tx_fifo u_fifo (
		.i_CLK       (i_CLK),
		.i_RESET     (i_RESET),
		.i_push      (push),
		.i_push_data (push_data),
		.i_pop       (pop),
		.o_head      (head),
		.o_full      (fifo_full),
		.o_empty     (fifo_empty),
		.o_level     (fifo_level)
	);

	uart_baud_gen u_baud (
		.i_CLK     (i_CLK),
		.i_RESET   (i_RESET),
		.i_divisor (divisor),
		.o_tick    (tick)
	);

	uart_transmitter u_tx (
		.i_CLK   (i_CLK),
		.i_RESET (i_RESET),
		.i_tick  (tick),
		.i_empty (fifo_empty),
		.i_data  (head),
		.o_pop   (pop),
		.o_busy  (tx_busy),
		.o_tx    (o_tx)
	);

endmodule

/* uart_wb_regs.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_wb_regs (
	input  logic                        i_CLK,
	input  logic                        i_RESET,
	input  uart_pkg::wb_req_t           i_wb,
	input  logic                        i_fifo_full,
	input  logic                        i_fifo_empty,
	input  logic [`UART_FIFO_AW:0]      i_fifo_level,
	input  logic                        i_tx_busy,
	output uart_pkg::wb_rsp_t           o_wb,
	output logic                        o_push,
	output logic [`UART_DATA_W-1:0]     o_push_data,
	output logic [`UART_DIV_W-1:0]      o_divisor
);

	localparam logic [`UART_DIV_W-1:0] div_reset_val = `UART_DIV_RESET;

	uart_pkg::reg_addr_e       addr;
	uart_pkg::uart_status_t    status;
	logic                      req;
	logic                      data_wr;
	logic                      accept;
	logic                      ack_q;
	logic [`UART_WB_DAT_W-1:0] rdata_next;
	logic [`UART_WB_DAT_W-1:0] rdata_q;
	logic [`UART_DIV_W-1:0]    divisor_q;

	assign addr    = uart_pkg::reg_addr_e'(i_wb.adr);
	// No new request while the previous ack is still on the bus
	assign req     = i_wb.cyc && i_wb.stb && !ack_q;
	assign data_wr = i_wb.we && (addr == uart_pkg::REG_DATA);

	// Data writes wait here until the FIFO has room
	assign accept = req && !(data_wr && i_fifo_full);

	assign o_push      = accept && data_wr;
	assign o_push_data = i_wb.dat[`UART_DATA_W-1:0];
	assign o_divisor   = divisor_q;

	always_comb
	begin
		status.busy  = i_tx_busy;
		status.full  = i_fifo_full;
		status.empty = i_fifo_empty;
		status.level = i_fifo_level;
	end

	// Read mux, unused bits and the data register read as zero
	always_comb
	begin
		rdata_next = '0;
		case (addr)
			uart_pkg::REG_STATUS:
				rdata_next[$bits(status)-1:0] = status;
			uart_pkg::REG_DIVISOR:
				rdata_next[`UART_DIV_W-1:0] = divisor_q;
			default:
				rdata_next = '0;
		endcase
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			ack_q     <= 1'b0;
			divisor_q <= div_reset_val;
		end
		else
		begin
			ack_q <= accept;
			if (accept && i_wb.we && addr == uart_pkg::REG_DIVISOR)
				divisor_q <= i_wb.dat[`UART_DIV_W-1:0];
		end
	end

	// Captured with the request, valid alongside ack
	always_ff @(posedge i_CLK)
	begin
		if (accept)
			rdata_q <= rdata_next;
	end

	assign o_wb = '{ack: ack_q, dat: rdata_q};

	// Classic cycle: one ack per request, master drops stb after it
	a_ack_single: assert property (@(posedge i_CLK) disable iff (i_RESET)
		o_wb.ack |=> !o_wb.ack);

	// Stalled data writes must never reach a full FIFO
	a_no_push_full: assert property (@(posedge i_CLK) disable iff (i_RESET)
		!(o_push && i_fifo_full));

endmodule
